// ==== design/btac_pkg.sv ====
`default_nettype none

package btac_pkg;

  localparam int pc_w = 32;
  localparam int sat_w = 2;

  // table depths
  localparam int btb_entries = 16;
  localparam int bht_entries = 64;

  // indices start at pc bit 1, bit 0 is always zero for fetch addresses
  localparam int btb_index_w = 4;
  localparam int bht_index_w = 6;

  // tag is every pc bit above the target buffer index
  localparam int btb_tag_w = pc_w - btb_index_w - 1;
  localparam int btb_entry_w = btb_tag_w + pc_w;

  typedef logic [pc_w-1:0] pc_t;

  typedef logic [btb_index_w-1:0] btb_index_t;

  typedef logic [bht_index_w-1:0] bht_index_t;

  typedef logic [btb_tag_w-1:0] btb_tag_t;

  // tag in the upper bits, target in the lower pc_w bits
  typedef logic [btb_entry_w-1:0] btb_entry_t;

  // bit 1 set means predict taken
  typedef logic [sat_w-1:0] sat_t;

endpackage

`default_nettype wire

// ==== design/prediction_ram.sv ====
`default_nettype none
`timescale 1ns/1ns

module prediction_ram #(
  parameter int entries = 16,
  parameter int width = 59
) (
  input  logic                       clock,
  input  logic                       wen,
  input  logic [$clog2(entries)-1:0] waddr,
  input  logic [$clog2(entries)-1:0] raddr0,
  input  logic [$clog2(entries)-1:0] raddr1,
  input  logic [width-1:0]           wdata,
  output logic [width-1:0]           rdata0,
  output logic [width-1:0]           rdata1
);

  // tables start out empty
  logic [width-1:0] mem [entries] = '{default: '0};

  always_ff @(posedge clock) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  // read before write on a shared index gives the old word
  always_ff @(posedge clock) begin
    rdata0 <= mem[raddr0];
    rdata1 <= mem[raddr1];
  end

endmodule

`default_nettype wire

// ==== design/btac_lookup.sv ====
`default_nettype none
`timescale 1ns/1ns

module btac_lookup (
  input  logic                  clock,
  input  logic                  reset,
  input  btac_pkg::pc_t         get_pc0,
  input  btac_pkg::pc_t         get_pc1,
  input  logic                  stall,
  input  logic                  clear,
  output btac_pkg::btb_index_t  btb_raddr0,
  output btac_pkg::btb_index_t  btb_raddr1,
  output btac_pkg::bht_index_t  bht_raddr0,
  output btac_pkg::bht_index_t  bht_raddr1,
  input  btac_pkg::btb_entry_t  btb_rdata0,
  input  btac_pkg::btb_entry_t  btb_rdata1,
  input  btac_pkg::sat_t        bht_rdata0,
  input  btac_pkg::sat_t        bht_rdata1,
  output logic                  pred_taken0,
  output logic                  pred_taken1,
  output btac_pkg::pc_t         pred_taddr0,
  output btac_pkg::pc_t         pred_taddr1,
  output btac_pkg::sat_t        pred_tsat0,
  output btac_pkg::sat_t        pred_tsat1
);

  btac_pkg::pc_t pc0_q;
  btac_pkg::pc_t pc1_q;
  btac_pkg::pc_t idx_pc0;
  btac_pkg::pc_t idx_pc1;
  btac_pkg::btb_tag_t stored_tag0;
  btac_pkg::btb_tag_t stored_tag1;
  btac_pkg::btb_tag_t fetch_tag0;
  btac_pkg::btb_tag_t fetch_tag1;
  logic hit0;
  logic hit1;
  logic pred_on;

  // pcs of the lookup now in flight through the tables
  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q <= '0;
      pc1_q <= '0;
    end else if (!clear) begin
      pc0_q <= get_pc0;
      pc1_q <= get_pc1;
    end
  end

  // under clear the held pcs keep the tables reading the same rows
  assign idx_pc0 = clear ? pc0_q : get_pc0;
  assign idx_pc1 = clear ? pc1_q : get_pc1;

  assign btb_raddr0 = idx_pc0[btac_pkg::btb_index_w:1];
  assign btb_raddr1 = idx_pc1[btac_pkg::btb_index_w:1];
  assign bht_raddr0 = idx_pc0[btac_pkg::bht_index_w:1];
  assign bht_raddr1 = idx_pc1[btac_pkg::bht_index_w:1];

  // tag check against the pc that made the read
  assign stored_tag0 = btb_rdata0[btac_pkg::btb_entry_w-1:btac_pkg::pc_w];
  assign stored_tag1 = btb_rdata1[btac_pkg::btb_entry_w-1:btac_pkg::pc_w];
  assign fetch_tag0 = pc0_q[btac_pkg::pc_w-1:btac_pkg::btb_index_w+1];
  assign fetch_tag1 = pc1_q[btac_pkg::pc_w-1:btac_pkg::btb_index_w+1];
  assign hit0 = stored_tag0 == fetch_tag0;
  assign hit1 = stored_tag1 == fetch_tag1;

  assign pred_on = !(stall || clear);

  assign pred_taken0 = pred_on && hit0 && bht_rdata0[1];
  assign pred_taken1 = pred_on && hit1 && bht_rdata1[1];
  assign pred_taddr0 = pred_on ? btb_rdata0[btac_pkg::pc_w-1:0] : '0;
  assign pred_taddr1 = pred_on ? btb_rdata1[btac_pkg::pc_w-1:0] : '0;
  assign pred_tsat0 = pred_on ? bht_rdata0 : '0;
  assign pred_tsat1 = pred_on ? bht_rdata1 : '0;

endmodule

`default_nettype wire

// ==== design/btac_resolve.sv ====
`default_nettype none
`timescale 1ns/1ns

module btac_resolve (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  clear,
  input  btac_pkg::pc_t         upd_pc0,
  input  btac_pkg::pc_t         upd_npc0,
  input  btac_pkg::pc_t         upd_addr0,
  input  logic                  upd_branch0,
  input  logic                  upd_jal0,
  input  logic                  upd_jump0,
  input  logic                  upd_taken0,
  input  btac_pkg::pc_t         upd_taddr0,
  input  btac_pkg::sat_t        upd_tsat0,
  input  btac_pkg::pc_t         upd_pc1,
  input  btac_pkg::pc_t         upd_npc1,
  input  btac_pkg::pc_t         upd_addr1,
  input  logic                  upd_branch1,
  input  logic                  upd_jal1,
  input  logic                  upd_jump1,
  input  logic                  upd_taken1,
  input  btac_pkg::pc_t         upd_taddr1,
  input  btac_pkg::sat_t        upd_tsat1,
  output logic                  btb_wen,
  output btac_pkg::btb_index_t  btb_waddr,
  output btac_pkg::btb_entry_t  btb_wdata,
  output logic                  bht_wen,
  output btac_pkg::bht_index_t  bht_waddr,
  output btac_pkg::sat_t        bht_wdata,
  output logic                  pred_hazard0,
  output logic                  pred_hazard1,
  output logic                  pred_miss,
  output btac_pkg::pc_t         pred_maddr
);

  // jal forces strongly taken, branches step one way and saturate
  function automatic btac_pkg::sat_t sat_next(input btac_pkg::sat_t sat, input logic jal,
                                              input logic jump);
    btac_pkg::sat_t next;
    next = sat;
    if (jal) begin
      next = 2'd3;
    end else if (jump && sat != 2'd3) begin
      next = sat + 2'd1;
    end else if (!jump && sat != 2'd0) begin
      next = sat - 2'd1;
    end
    return next;
  endfunction

  function automatic logic slot_miss(input logic taken, input logic jump, input logic branch,
                                     input btac_pkg::pc_t addr, input btac_pkg::pc_t taddr);
    logic miss;
    miss = 1'b0;
    if (taken) begin
      if (jump) begin
        // right direction, maybe wrong target
        miss = addr != taddr;
      end else if (branch) begin
        miss = 1'b1;
      end
    end else if (jump) begin
      miss = 1'b1;
    end
    return miss;
  endfunction

  function automatic btac_pkg::pc_t slot_maddr(input logic taken, input logic jump,
                                               input logic branch, input btac_pkg::pc_t addr,
                                               input btac_pkg::pc_t npc);
    btac_pkg::pc_t maddr;
    maddr = '0;
    if (jump) begin
      maddr = addr;
    end else if (taken && branch) begin
      // fall through to the sequential pc
      maddr = npc;
    end
    return maddr;
  endfunction

  logic act0;
  logic act1;
  logic wen;
  btac_pkg::pc_t sel_pc;
  btac_pkg::pc_t sel_addr;
  btac_pkg::sat_t sel_sat;
  logic miss0;
  logic miss1;
  btac_pkg::pc_t maddr0;
  btac_pkg::pc_t maddr1;

  // slot 0 has priority for the single table write port
  assign act0 = upd_branch0 || upd_jal0;
  assign act1 = upd_branch1 || upd_jal1;
  assign wen = !clear && (act0 || act1);

  assign sel_pc = act0 ? upd_pc0 : upd_pc1;
  assign sel_addr = act0 ? upd_addr0 : upd_addr1;
  assign sel_sat = act0 ? sat_next(upd_tsat0, upd_jal0, upd_jump0)
                        : sat_next(upd_tsat1, upd_jal1, upd_jump1);

  assign btb_wen = wen;
  assign btb_waddr = sel_pc[btac_pkg::btb_index_w:1];
  assign btb_wdata = {sel_pc[btac_pkg::pc_w-1:btac_pkg::btb_index_w+1], sel_addr};

  assign bht_wen = wen;
  assign bht_waddr = sel_pc[btac_pkg::bht_index_w:1];
  assign bht_wdata = sel_sat;

  assign miss0 = !clear && slot_miss(upd_taken0, upd_jump0, upd_branch0, upd_addr0, upd_taddr0);
  assign miss1 = !clear && slot_miss(upd_taken1, upd_jump1, upd_branch1, upd_addr1, upd_taddr1);
  assign maddr0 = clear ? '0 : slot_maddr(upd_taken0, upd_jump0, upd_branch0, upd_addr0, upd_npc0);
  assign maddr1 = clear ? '0 : slot_maddr(upd_taken1, upd_jump1, upd_branch1, upd_addr1, upd_npc1);

  assign pred_hazard0 = miss0;
  assign pred_hazard1 = miss1;

  // redirect to fetch, one cycle after resolve
  always_ff @(posedge clock) begin
    if (!reset) begin
      pred_miss <= 1'b0;
      pred_maddr <= '0;
    end else begin
      pred_miss <= miss0 || miss1;
      pred_maddr <= miss0 ? maddr0 : maddr1;
    end
  end

endmodule

`default_nettype wire

// ==== design/btac.sv ====
`default_nettype none
`timescale 1ns/1ns

module btac (
  input  logic            clock,
  input  logic            reset,
  input  btac_pkg::pc_t   get_pc0,
  input  btac_pkg::pc_t   get_pc1,
  input  logic            stall,
  input  logic            clear,
  input  btac_pkg::pc_t   upd_pc0,
  input  btac_pkg::pc_t   upd_npc0,
  input  btac_pkg::pc_t   upd_addr0,
  input  logic            upd_branch0,
  input  logic            upd_jal0,
  input  logic            upd_jump0,
  input  logic            upd_taken0,
  input  btac_pkg::pc_t   upd_taddr0,
  input  btac_pkg::sat_t  upd_tsat0,
  input  btac_pkg::pc_t   upd_pc1,
  input  btac_pkg::pc_t   upd_npc1,
  input  btac_pkg::pc_t   upd_addr1,
  input  logic            upd_branch1,
  input  logic            upd_jal1,
  input  logic            upd_jump1,
  input  logic            upd_taken1,
  input  btac_pkg::pc_t   upd_taddr1,
  input  btac_pkg::sat_t  upd_tsat1,
  output logic            pred_taken0,
  output logic            pred_taken1,
  output btac_pkg::pc_t   pred_taddr0,
  output btac_pkg::pc_t   pred_taddr1,
  output btac_pkg::sat_t  pred_tsat0,
  output btac_pkg::sat_t  pred_tsat1,
  output logic            pred_hazard0,
  output logic            pred_hazard1,
  output logic            pred_miss,
  output btac_pkg::pc_t   pred_maddr
);

  btac_pkg::btb_index_t btb_raddr0;
  btac_pkg::btb_index_t btb_raddr1;
  btac_pkg::btb_index_t btb_waddr;
  btac_pkg::btb_entry_t btb_rdata0;
  btac_pkg::btb_entry_t btb_rdata1;
  btac_pkg::btb_entry_t btb_wdata;
  logic btb_wen;
  btac_pkg::bht_index_t bht_raddr0;
  btac_pkg::bht_index_t bht_raddr1;
  btac_pkg::bht_index_t bht_waddr;
  btac_pkg::sat_t bht_rdata0;
  btac_pkg::sat_t bht_rdata1;
  btac_pkg::sat_t bht_wdata;
  logic bht_wen;

  btac_lookup i_lookup (
    .clock(clock), .reset(reset), .get_pc0(get_pc0), .get_pc1(get_pc1),
    .stall(stall), .clear(clear),
    .btb_raddr0(btb_raddr0), .btb_raddr1(btb_raddr1),
    .bht_raddr0(bht_raddr0), .bht_raddr1(bht_raddr1),
    .btb_rdata0(btb_rdata0), .btb_rdata1(btb_rdata1),
    .bht_rdata0(bht_rdata0), .bht_rdata1(bht_rdata1),
    .pred_taken0(pred_taken0), .pred_taken1(pred_taken1),
    .pred_taddr0(pred_taddr0), .pred_taddr1(pred_taddr1),
    .pred_tsat0(pred_tsat0), .pred_tsat1(pred_tsat1)
  );

  btac_resolve i_resolve (
    .clock(clock), .reset(reset), .clear(clear),
    .upd_pc0(upd_pc0), .upd_npc0(upd_npc0), .upd_addr0(upd_addr0),
    .upd_branch0(upd_branch0), .upd_jal0(upd_jal0), .upd_jump0(upd_jump0),
    .upd_taken0(upd_taken0), .upd_taddr0(upd_taddr0), .upd_tsat0(upd_tsat0),
    .upd_pc1(upd_pc1), .upd_npc1(upd_npc1), .upd_addr1(upd_addr1),
    .upd_branch1(upd_branch1), .upd_jal1(upd_jal1), .upd_jump1(upd_jump1),
    .upd_taken1(upd_taken1), .upd_taddr1(upd_taddr1), .upd_tsat1(upd_tsat1),
    .btb_wen(btb_wen), .btb_waddr(btb_waddr), .btb_wdata(btb_wdata),
    .bht_wen(bht_wen), .bht_waddr(bht_waddr), .bht_wdata(bht_wdata),
    .pred_hazard0(pred_hazard0), .pred_hazard1(pred_hazard1),
    .pred_miss(pred_miss), .pred_maddr(pred_maddr)
  );

  // target buffer, tag and target per entry
  prediction_ram #(
    .entries(btac_pkg::btb_entries),
    .width(btac_pkg::btb_entry_w)
  ) btb_ram (
    .clock(clock), .wen(btb_wen), .waddr(btb_waddr),
    .raddr0(btb_raddr0), .raddr1(btb_raddr1), .wdata(btb_wdata),
    .rdata0(btb_rdata0), .rdata1(btb_rdata1)
  );

  // branch history counters
  prediction_ram #(
    .entries(btac_pkg::bht_entries),
    .width(btac_pkg::sat_w)
  ) bht_ram (
    .clock(clock), .wen(bht_wen), .waddr(bht_waddr),
    .raddr0(bht_raddr0), .raddr1(bht_raddr1), .wdata(bht_wdata),
    .rdata0(bht_rdata0), .rdata1(bht_rdata1)
  );

endmodule

`default_nettype wire

// ==== tb/btac_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module btac_tb;

  localparam int clk_period = 40;
  localparam int vector_count = 34;
  localparam int field_count = 25;
  localparam int max_file_lines = 64;
  localparam string stim_path = "tb/btac_stim.txt";

  logic clock;
  logic reset;
  logic stall;
  logic clear;
  btac_pkg::pc_t get_pc0, get_pc1;
  btac_pkg::pc_t upd_pc0, upd_npc0, upd_addr0, upd_taddr0;
  btac_pkg::pc_t upd_pc1, upd_npc1, upd_addr1, upd_taddr1;
  logic upd_branch0, upd_jal0, upd_jump0, upd_taken0;
  logic upd_branch1, upd_jal1, upd_jump1, upd_taken1;
  btac_pkg::sat_t upd_tsat0, upd_tsat1;
  logic pred_taken0, pred_taken1;
  btac_pkg::pc_t pred_taddr0, pred_taddr1;
  btac_pkg::sat_t pred_tsat0, pred_tsat1;
  logic pred_hazard0, pred_hazard1;
  logic pred_miss;
  btac_pkg::pc_t pred_maddr;

  // one row per cycle, inputs first and expected outputs from column 16
  logic [31:0] stim [vector_count][field_count];
  int loaded;
  int checks;
  int errors;
  int tests;
  int test_errors;
  int test_cycles;

  btac i_btac (
    .clock(clock), .reset(reset), .get_pc0(get_pc0), .get_pc1(get_pc1),
    .stall(stall), .clear(clear),
    .upd_pc0(upd_pc0), .upd_npc0(upd_npc0), .upd_addr0(upd_addr0),
    .upd_branch0(upd_branch0), .upd_jal0(upd_jal0), .upd_jump0(upd_jump0),
    .upd_taken0(upd_taken0), .upd_taddr0(upd_taddr0), .upd_tsat0(upd_tsat0),
    .upd_pc1(upd_pc1), .upd_npc1(upd_npc1), .upd_addr1(upd_addr1),
    .upd_branch1(upd_branch1), .upd_jal1(upd_jal1), .upd_jump1(upd_jump1),
    .upd_taken1(upd_taken1), .upd_taddr1(upd_taddr1), .upd_tsat1(upd_tsat1),
    .pred_taken0(pred_taken0), .pred_taken1(pred_taken1),
    .pred_taddr0(pred_taddr0), .pred_taddr1(pred_taddr1),
    .pred_tsat0(pred_tsat0), .pred_tsat1(pred_tsat1),
    .pred_hazard0(pred_hazard0), .pred_hazard1(pred_hazard1),
    .pred_miss(pred_miss), .pred_maddr(pred_maddr)
  );

  always #(clk_period / 2) clock = ~clock;

  task automatic load_stim();
    int fd;
    int got;
    string line;
    logic [31:0] row [field_count];
    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", stim_path);
      errors++;
      return;
    end
    for (int n = 0; n < max_file_lines && loaded < vector_count; n++) begin
      if ($fgets(line, fd) == 0) begin
        break;
      end
      // comment and empty lines
      if (line.len() < 2 || line.getc(0) == "/") begin
        continue;
      end
      got = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                    row[0], row[1], row[2], row[3], row[4], row[5], row[6], row[7],
                    row[8], row[9], row[10], row[11], row[12], row[13], row[14],
                    row[15], row[16], row[17], row[18], row[19], row[20], row[21],
                    row[22], row[23], row[24]);
      if (got != field_count) begin
        $display("stimulus line %0d holds %0d fields instead of %0d", n + 1, got, field_count);
        errors++;
      end else begin
        stim[loaded] = row;
        loaded++;
      end
    end
    $fclose(fd);
    if (loaded < vector_count) begin
      $display("the stimulus file gave only %0d of %0d vectors", loaded, vector_count);
      errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic idle_inputs();
    get_pc0 = '0;
    get_pc1 = '0;
    stall = 1'b0;
    clear = 1'b0;
    {upd_pc0, upd_npc0, upd_addr0, upd_taddr0, upd_tsat0} = '0;
    {upd_branch0, upd_jal0, upd_jump0, upd_taken0} = '0;
    {upd_pc1, upd_npc1, upd_addr1, upd_taddr1, upd_tsat1} = '0;
    {upd_branch1, upd_jal1, upd_jump1, upd_taken1} = '0;
  endtask

  // flag nibble is branch, jal, jump, taken from bit 3 down
  task automatic drive_vector(input int k);
    get_pc0 <= stim[k][1];
    get_pc1 <= stim[k][2];
    stall <= stim[k][3][1];
    clear <= stim[k][3][0];
    upd_pc0 <= stim[k][4];
    upd_npc0 <= stim[k][5];
    upd_addr0 <= stim[k][6];
    upd_branch0 <= stim[k][7][3];
    upd_jal0 <= stim[k][7][2];
    upd_jump0 <= stim[k][7][1];
    upd_taken0 <= stim[k][7][0];
    upd_taddr0 <= stim[k][8];
    upd_tsat0 <= stim[k][9][1:0];
    upd_pc1 <= stim[k][10];
    upd_npc1 <= stim[k][11];
    upd_addr1 <= stim[k][12];
    upd_branch1 <= stim[k][13][3];
    upd_jal1 <= stim[k][13][2];
    upd_jump1 <= stim[k][13][1];
    upd_taken1 <= stim[k][13][0];
    upd_taddr1 <= stim[k][14];
    upd_tsat1 <= stim[k][15][1:0];
  endtask

  task automatic check_vector(input int k);
    check_value("pred_taken0", stim[k][16], 32'(pred_taken0));
    check_value("pred_taddr0", stim[k][17], pred_taddr0);
    check_value("pred_tsat0", stim[k][18], 32'(pred_tsat0));
    check_value("pred_taken1", stim[k][19], 32'(pred_taken1));
    check_value("pred_taddr1", stim[k][20], pred_taddr1);
    check_value("pred_tsat1", stim[k][21], 32'(pred_tsat1));
    check_value("pred_hazard0", 32'(stim[k][22][0]), 32'(pred_hazard0));
    check_value("pred_hazard1", 32'(stim[k][22][1]), 32'(pred_hazard1));
    check_value("pred_miss", stim[k][23], 32'(pred_miss));
    check_value("pred_maddr", stim[k][24], pred_maddr);
  endtask

  task automatic finish_run();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  initial begin
    logic last_of_test;
    clock = 1'b0;
    reset = 1'b0;
    idle_inputs();
    load_stim();
    if (loaded == vector_count && errors == 0) begin
      repeat (4) @(posedge clock);
      reset <= 1'b1;
      for (int k = 0; k < vector_count; k++) begin
        @(posedge clock);
        drive_vector(k);
        // sample just ahead of the next edge
        #(clk_period - 5);
        check_vector(k);
        test_cycles++;
        if (k == vector_count - 1) begin
          last_of_test = 1'b1;
        end else begin
          last_of_test = stim[k + 1][0] != stim[k][0];
        end
        if (last_of_test) begin
          $display("test %0d done: %0d cycles, %0d mismatches", stim[k][0], test_cycles,
                   test_errors);
          tests++;
          test_cycles = 0;
          test_errors = 0;
        end
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== tb/btac_stim.txt ====
// test gpc0 gpc1 sc, slot0: pc npc addr f taddr tsat, slot1 the same, then expected outputs
// tk0 ta0 ts0 tk1 ta1 ts1 hz miss maddr; sc={stall,clear} f={branch,jal,jump,taken} hz={hz1,hz0}
1 104 108 0  0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
1 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
2 0 0 0  104 108 400 6 0 0  0 0 0 0 0 0  0 0 0 0 0 0 1 0 0
2 104 204 0  0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0 0 1 400
2 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1 400 3 0 400 3 0 0 0
3 0 0 0  108 10c 500 6 0 0  0 0 0 0 0 0  0 0 0 0 0 0 1 0 0
3 108 0 0  108 10c 500 9 500 3  0 0 0 0 0 0  0 0 0 0 0 0 1 1 500
3 108 0 0  108 10c 500 9 500 2  0 0 0 0 0 0  1 500 3 0 0 0 1 1 10c
3 108 0 0  108 10c 500 8 500 1  0 0 0 0 0 0  1 500 2 0 0 0 0 1 10c
3 108 0 0  108 10c 500 8 500 0  0 0 0 0 0 0  0 500 1 0 0 0 0 0 0
3 108 0 0  108 10c 500 a 500 0  0 0 0 0 0 0  0 500 0 0 0 0 1 0 0
3 108 0 0  108 10c 500 a 500 1  0 0 0 0 0 0  0 500 0 0 0 0 1 1 500
3 108 0 0  108 10c 500 b 500 2  0 0 0 0 0 0  0 500 1 0 0 0 0 1 500
3 108 0 0  108 10c 500 b 500 3  0 0 0 0 0 0  1 500 2 0 0 0 0 0 0
3 108 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1 500 3 0 0 0 0 0 0
3 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1 500 3 0 0 0 0 0 0
4 0 0 0  1010 1014 600 b 680 2  0 0 0 0 0 0  0 0 0 0 0 0 1 0 0
4 0 0 0  0 0 0 0 0 0  1014 1018 700 b 780 2  0 0 0 0 0 0 2 1 600
4 0 0 0  1010 1014 600 9 600 3  0 0 0 0 0 0  0 0 0 0 0 0 1 1 700
4 0 0 0  0 0 0 0 0 0  1014 1018 700 9 700 3  0 0 0 0 0 0 2 1 1014
4 0 0 0  1010 1014 600 a 0 1  0 0 0 0 0 0  0 0 0 0 0 0 1 1 1018
4 0 0 0  0 0 0 0 0 0  1014 1018 700 6 0 0  0 0 0 0 0 0 2 1 600
4 0 0 0  1010 1014 600 b 600 2  1014 1018 700 7 700 3  0 0 0 0 0 0 0 1 700
4 0 0 0  1010 1014 600 9 600 3  1014 1018 700 a 0 1  0 0 0 0 0 0 3 0 700
4 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0 0 1 1014
5 0 0 0  0 0 0 0 0 0  301c 3020 900 6 0 0  0 0 0 0 0 0 2 0 0
5 0 0 0  2018 201c a00 6 0 0  301c 3020 990 9 900 3  0 0 0 0 0 0 3 1 900
5 2018 301c 0  0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0 0 1 a00
5 104 108 0  0 0 0 0 0 0  0 0 0 0 0 0  1 a00 3 1 900 3 0 0 0
6 104 108 2  402c 4030 b00 6 0 0  0 0 0 0 0 0  0 0 0 0 0 0 1 0 0
6 402c 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1 400 3 1 500 3 0 1 b00
6 104 108 1  5032 5034 c00 6 0 0  0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
6 5032 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1 b00 3 0 0 0 0 0 0
6 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0 0 0 0

// ==== btac.f ====
design/btac_pkg.sv
design/prediction_ram.sv
design/btac_lookup.sv
design/btac_resolve.sv
design/btac.sv
tb/btac_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the btac testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module btac_tb -Mdir obj_dir -f btac.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vbtac_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qxF '>>> PASS'; then
  exit 0
fi
echo "simulation did not pass"
exit 1
